// ==== verilog/pll_drp_pkg.sv ====
`default_nettype none

package pll_drp_pkg;

   typedef logic [6:0]  drp_addr_t;
   typedef logic [15:0] drp_data_t;
   typedef logic [3:0]  step_t;
   typedef logic [5:0]  time_t;
   typedef logic [2:0]  phase_mux_t;
   typedef logic [39:0] lock_word_t;
   typedef logic [9:0]  filter_word_t;

   localparam int NUM_STEPS = 13;

   // Sequence order
   localparam step_t STEP_POWER         = 4'd0;
   localparam step_t STEP_CLKOUT0_REG1  = 4'd1;
   localparam step_t STEP_CLKOUT0_REG2  = 4'd2;
   localparam step_t STEP_CLKOUT1_REG1  = 4'd3;
   localparam step_t STEP_CLKOUT1_REG2  = 4'd4;
   localparam step_t STEP_DIVCLK        = 4'd5;
   localparam step_t STEP_CLKFBOUT_REG1 = 4'd6;
   localparam step_t STEP_CLKFBOUT_REG2 = 4'd7;
   localparam step_t STEP_LOCK_REG1     = 4'd8;
   localparam step_t STEP_LOCK_REG2     = 4'd9;
   localparam step_t STEP_LOCK_REG3     = 4'd10;
   localparam step_t STEP_FILT_REG1     = 4'd11;
   localparam step_t STEP_FILT_REG2     = 4'd12;

   // PLL DRP register map
   localparam drp_addr_t ADDR_POWER         = 7'h28;
   localparam drp_addr_t ADDR_CLKOUT0_REG1  = 7'h08;
   localparam drp_addr_t ADDR_CLKOUT0_REG2  = 7'h09;
   localparam drp_addr_t ADDR_CLKOUT1_REG1  = 7'h0A;
   localparam drp_addr_t ADDR_CLKOUT1_REG2  = 7'h0B;
   localparam drp_addr_t ADDR_DIVCLK        = 7'h16;
   localparam drp_addr_t ADDR_CLKFBOUT_REG1 = 7'h14;
   localparam drp_addr_t ADDR_CLKFBOUT_REG2 = 7'h15;
   localparam drp_addr_t ADDR_LOCK_REG1     = 7'h18;
   localparam drp_addr_t ADDR_LOCK_REG2     = 7'h19;
   localparam drp_addr_t ADDR_LOCK_REG3     = 7'h1A;
   localparam drp_addr_t ADDR_FILT_REG1     = 7'h4E;
   localparam drp_addr_t ADDR_FILT_REG2     = 7'h4F;

   // Counter register word in its register 1 and register 2 views
   typedef union packed {
      struct packed {
         phase_mux_t phase_mux;
         logic       reserved;
         time_t      high_time;
         time_t      low_time;
      } reg1;
      struct packed {
         logic [7:0] reserved;
         logic       edge_en;
         logic       no_count;
         time_t      delay_time;
      } reg2;
   } clk_reg_t;

endpackage

`default_nettype wire

// ==== verilog/pll_lock_filter_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_lock_filter_table (
   input  wire                          dclk,
   input  wire pll_drp_pkg::time_t      divclk_high_time,
   input  wire pll_drp_pkg::time_t      divclk_low_time,
   input  wire                          divclk_no_count,
   output pll_drp_pkg::lock_word_t      lock_word,
   output pll_drp_pkg::filter_word_t    filter_word
);

   logic [7:0] divclk;

   assign divclk = divclk_no_count ? 8'd0 :
                   8'(divclk_high_time) + 8'(divclk_low_time) - 8'd1;

   always_ff @(posedge dclk) begin
      // Bandwidth optimized filter settings
      case (divclk) inside
         8'd2:                      filter_word <= 10'b0101_1111_00;
         8'd3:                      filter_word <= 10'b0111_1111_00;
         8'd4:                      filter_word <= 10'b0111_1011_00;
         8'd5:                      filter_word <= 10'b1101_0111_00;
         8'd6:                      filter_word <= 10'b1110_1011_00;
         8'd7:                      filter_word <= 10'b1110_1101_00;
         8'd8, 8'd11:               filter_word <= 10'b1111_1101_00;
         8'd9:                      filter_word <= 10'b1111_0111_00;
         8'd10:                     filter_word <= 10'b1111_1011_00;
         8'd12:                     filter_word <= 10'b1111_0011_00;
         8'd13:                     filter_word <= 10'b1110_0101_00;
         [8'd14:8'd17]:             filter_word <= 10'b1111_0101_00;
         [8'd18:8'd21]:             filter_word <= 10'b0111_0110_00;
         [8'd22:8'd24]:             filter_word <= 10'b0101_1100_00;
         [8'd25:8'd32]:             filter_word <= 10'b1100_0001_00;
         [8'd33:8'd35]:             filter_word <= 10'b0100_0010_00;
         [8'd36:8'd38], [8'd40:8'd52]: filter_word <= 10'b0010_1000_00;
         8'd39:                     filter_word <= 10'b0011_0100_00;
         [8'd53:8'd59]:             filter_word <= 10'b0100_1100_00;
         [8'd60:8'd63]:             filter_word <= 10'b0010_0100_00;
         // Counts 0 and 1, and anything out of range
         default:                   filter_word <= 10'b0011_0111_00;
      endcase

      case (divclk) inside
         8'd2:          lock_word <= 40'b01000_01000_1111101000_1111101001_0000000001;
         8'd3:          lock_word <= 40'b01011_01011_1111101000_1111101001_0000000001;
         8'd4:          lock_word <= 40'b01110_01110_1111101000_1111101001_0000000001;
         8'd5:          lock_word <= 40'b10001_10001_1111101000_1111101001_0000000001;
         8'd6:          lock_word <= 40'b10011_10011_1111101000_1111101001_0000000001;
         8'd7:          lock_word <= 40'b10110_10110_1111101000_1111101001_0000000001;
         8'd8:          lock_word <= 40'b11001_11001_1111101000_1111101001_0000000001;
         8'd9:          lock_word <= 40'b11100_11100_1111101000_1111101001_0000000001;
         8'd10:         lock_word <= 40'b11111_11111_1110000100_1111101001_0000000001;
         8'd11:         lock_word <= 40'b11111_11111_1100111001_1111101001_0000000001;
         8'd12:         lock_word <= 40'b11111_11111_1011101110_1111101001_0000000001;
         8'd13:         lock_word <= 40'b11111_11111_1010111100_1111101001_0000000001;
         8'd14:         lock_word <= 40'b11111_11111_1010001010_1111101001_0000000001;
         8'd15:         lock_word <= 40'b11111_11111_1001110001_1111101001_0000000001;
         8'd16:         lock_word <= 40'b11111_11111_1000111111_1111101001_0000000001;
         8'd17:         lock_word <= 40'b11111_11111_1000100110_1111101001_0000000001;
         8'd18:         lock_word <= 40'b11111_11111_1000001101_1111101001_0000000001;
         8'd19:         lock_word <= 40'b11111_11111_0111110100_1111101001_0000000001;
         8'd20:         lock_word <= 40'b11111_11111_0111011011_1111101001_0000000001;
         8'd21:         lock_word <= 40'b11111_11111_0111000010_1111101001_0000000001;
         8'd22:         lock_word <= 40'b11111_11111_0110101001_1111101001_0000000001;
         [8'd23:8'd24]: lock_word <= 40'b11111_11111_0110010000_1111101001_0000000001;
         8'd25:         lock_word <= 40'b11111_11111_0101110111_1111101001_0000000001;
         [8'd26:8'd27]: lock_word <= 40'b11111_11111_0101011110_1111101001_0000000001;
         [8'd28:8'd29]: lock_word <= 40'b11111_11111_0101000101_1111101001_0000000001;
         [8'd30:8'd32]: lock_word <= 40'b11111_11111_0100101100_1111101001_0000000001;
         [8'd33:8'd35]: lock_word <= 40'b11111_11111_0100010011_1111101001_0000000001;
         [8'd36:8'd63]: lock_word <= 40'b11111_11111_0011111010_1111101001_0000000001;
         // Same fallback as the filter table
         default:       lock_word <= 40'b00110_00110_1111101000_1111101001_0000000001;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/pll_step_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_step_rom (
   input  wire pll_drp_pkg::step_t        step,
   input  wire pll_drp_pkg::time_t        clkout0_high_time,
   input  wire pll_drp_pkg::time_t        clkout0_low_time,
   input  wire pll_drp_pkg::phase_mux_t   clkout0_phase_mux,
   input  wire                            clkout0_edge,
   input  wire                            clkout0_no_count,
   input  wire pll_drp_pkg::time_t        clkout0_delay_time,
   input  wire pll_drp_pkg::time_t        clkout1_high_time,
   input  wire pll_drp_pkg::time_t        clkout1_low_time,
   input  wire pll_drp_pkg::phase_mux_t   clkout1_phase_mux,
   input  wire                            clkout1_edge,
   input  wire                            clkout1_no_count,
   input  wire pll_drp_pkg::time_t        clkout1_delay_time,
   input  wire pll_drp_pkg::time_t        clkfbout_high_time,
   input  wire pll_drp_pkg::time_t        clkfbout_low_time,
   input  wire pll_drp_pkg::phase_mux_t   clkfbout_phase_mux,
   input  wire                            clkfbout_edge,
   input  wire                            clkfbout_no_count,
   input  wire pll_drp_pkg::time_t        clkfbout_delay_time,
   input  wire pll_drp_pkg::time_t        divclk_high_time,
   input  wire pll_drp_pkg::time_t        divclk_low_time,
   input  wire                            divclk_edge,
   input  wire                            divclk_no_count,
   input  wire pll_drp_pkg::lock_word_t   lock_word,
   input  wire pll_drp_pkg::filter_word_t filter_word,
   output pll_drp_pkg::drp_addr_t         daddr_step,
   output pll_drp_pkg::drp_data_t         keep_mask,
   output pll_drp_pkg::drp_data_t         set_bits
);
   import pll_drp_pkg::*;

   function automatic drp_data_t reg1_word(phase_mux_t phase_mux, time_t high_time,
                                           time_t low_time);
      clk_reg_t w;
      w                = '0;
      w.reg1.phase_mux = phase_mux;
      w.reg1.high_time = high_time;
      w.reg1.low_time  = low_time;
      return w;
   endfunction

   function automatic drp_data_t reg2_word(logic edge_en, logic no_count, time_t delay_time);
      clk_reg_t w;
      w                 = '0;
      w.reg2.edge_en    = edge_en;
      w.reg2.no_count   = no_count;
      w.reg2.delay_time = delay_time;
      return w;
   endfunction

   always_comb begin
      case (step)
         STEP_POWER:         daddr_step = ADDR_POWER;
         STEP_CLKOUT0_REG1:  daddr_step = ADDR_CLKOUT0_REG1;
         STEP_CLKOUT0_REG2:  daddr_step = ADDR_CLKOUT0_REG2;
         STEP_CLKOUT1_REG1:  daddr_step = ADDR_CLKOUT1_REG1;
         STEP_CLKOUT1_REG2:  daddr_step = ADDR_CLKOUT1_REG2;
         STEP_DIVCLK:        daddr_step = ADDR_DIVCLK;
         STEP_CLKFBOUT_REG1: daddr_step = ADDR_CLKFBOUT_REG1;
         STEP_CLKFBOUT_REG2: daddr_step = ADDR_CLKFBOUT_REG2;
         STEP_LOCK_REG1:     daddr_step = ADDR_LOCK_REG1;
         STEP_LOCK_REG2:     daddr_step = ADDR_LOCK_REG2;
         STEP_LOCK_REG3:     daddr_step = ADDR_LOCK_REG3;
         STEP_FILT_REG1:     daddr_step = ADDR_FILT_REG1;
         STEP_FILT_REG2:     daddr_step = ADDR_FILT_REG2;
         default:            daddr_step = '0;
      endcase

      // Bits of the old register value that survive the write
      case (step)
         STEP_CLKOUT0_REG1, STEP_CLKOUT1_REG1, STEP_CLKFBOUT_REG1: keep_mask = 16'h1000;
         STEP_CLKOUT0_REG2, STEP_CLKOUT1_REG2, STEP_CLKFBOUT_REG2: keep_mask = 16'hFC00;
         STEP_LOCK_REG1:                 keep_mask = 16'hFC00;
         STEP_DIVCLK:                    keep_mask = 16'hC000;
         STEP_LOCK_REG2, STEP_LOCK_REG3: keep_mask = 16'h8000;
         STEP_FILT_REG1:                 keep_mask = 16'h66FF;
         STEP_FILT_REG2:                 keep_mask = 16'h666F;
         default:                        keep_mask = 16'h0000;
      endcase

      case (step)
         STEP_POWER:         set_bits = 16'hFFFF;
         STEP_CLKOUT0_REG1:
            set_bits = reg1_word(clkout0_phase_mux, clkout0_high_time, clkout0_low_time);
         STEP_CLKOUT0_REG2:
            set_bits = reg2_word(clkout0_edge, clkout0_no_count, clkout0_delay_time);
         STEP_CLKOUT1_REG1:
            set_bits = reg1_word(clkout1_phase_mux, clkout1_high_time, clkout1_low_time);
         STEP_CLKOUT1_REG2:
            set_bits = reg2_word(clkout1_edge, clkout1_no_count, clkout1_delay_time);
         STEP_DIVCLK:
            set_bits = {2'b00, divclk_edge, divclk_no_count, divclk_high_time, divclk_low_time};
         STEP_CLKFBOUT_REG1:
            set_bits = reg1_word(clkfbout_phase_mux, clkfbout_high_time, clkfbout_low_time);
         STEP_CLKFBOUT_REG2:
            set_bits = reg2_word(clkfbout_edge, clkfbout_no_count, clkfbout_delay_time);
         STEP_LOCK_REG1:     set_bits = {6'b000000, lock_word[29:20]};
         STEP_LOCK_REG2:     set_bits = {1'b0, lock_word[34:30], lock_word[9:0]};
         STEP_LOCK_REG3:     set_bits = {1'b0, lock_word[39:35], lock_word[19:10]};
         STEP_FILT_REG1:
            set_bits = {filter_word[9], 2'b00, filter_word[8:7], 2'b00, filter_word[6], 8'h00};
         STEP_FILT_REG2:
            set_bits = {filter_word[5], 2'b00, filter_word[4:3], 2'b00,
                        filter_word[2:1], 2'b00, filter_word[0], 4'h0};
         default:            set_bits = 16'h0000;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/pll_drp_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_drp_fsm (
   input  wire                         dclk,
   input  wire                         rst,
   input  wire                         start_reconfig,
   input  wire                         locked,
   input  wire                         drdy,
   input  wire pll_drp_pkg::drp_data_t dout,
   input  wire pll_drp_pkg::drp_addr_t daddr_step,
   input  wire pll_drp_pkg::drp_data_t keep_mask,
   input  wire pll_drp_pkg::drp_data_t set_bits,
   output pll_drp_pkg::step_t          step,
   output pll_drp_pkg::drp_addr_t      daddr,
   output pll_drp_pkg::drp_data_t      din,
   output logic                        den,
   output logic                        dwe,
   output logic                        rst_pll,
   output logic                        ready,
   output logic                        reconfig_done
);
   import pll_drp_pkg::*;

   localparam logic [3:0] RESTART    = 4'd0;
   localparam logic [3:0] WAIT_LOCK  = 4'd1;
   localparam logic [3:0] WAIT_START = 4'd2;
   localparam logic [3:0] ADDRESS    = 4'd3;
   localparam logic [3:0] WAIT_READ  = 4'd4;
   localparam logic [3:0] MASK       = 4'd5;
   localparam logic [3:0] SET        = 4'd6;
   localparam logic [3:0] WRITE      = 4'd7;
   localparam logic [3:0] WAIT_WRITE = 4'd8;

   localparam step_t LAST_STEP = step_t'(NUM_STEPS - 1);

   logic [3:0] state;

   assign ready = (state == WAIT_START);

   always_ff @(posedge dclk) begin
      // DRP strobes and the done flag are single-cycle pulses
      den           <= 1'b0;
      dwe           <= 1'b0;
      reconfig_done <= 1'b0;
      if (rst) begin
         state   <= RESTART;
         step    <= '0;
         rst_pll <= 1'b0;
      end else begin
         case (state)
            RESTART: begin
               rst_pll <= 1'b1;
               step    <= '0;
               state   <= WAIT_LOCK;
            end
            WAIT_LOCK: begin
               rst_pll <= 1'b0;
               step    <= '0;
               // Stale lock while the PLL is still in reset
               if (locked && !rst_pll) begin
                  state <= WAIT_START;
               end
            end
            WAIT_START: begin
               if (start_reconfig) begin
                  state <= ADDRESS;
               end
            end
            ADDRESS: begin
               rst_pll <= 1'b1;
               daddr   <= daddr_step;
               den     <= 1'b1;
               state   <= WAIT_READ;
            end
            WAIT_READ: begin
               // dout is only valid alongside drdy
               if (drdy) begin
                  din   <= dout;
                  state <= MASK;
               end
            end
            MASK: begin
               din   <= din & keep_mask;
               state <= SET;
            end
            SET: begin
               din   <= din | set_bits;
               state <= WRITE;
            end
            WRITE: begin
               den   <= 1'b1;
               dwe   <= 1'b1;
               state <= WAIT_WRITE;
            end
            WAIT_WRITE: begin
               if (drdy) begin
                  if (step == LAST_STEP) begin
                     rst_pll       <= 1'b0;
                     reconfig_done <= 1'b1;
                     state         <= WAIT_LOCK;
                  end else begin
                     step  <= step + 1'b1;
                     state <= ADDRESS;
                  end
               end
            end
            default: state <= RESTART;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pll_reconfig_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_top (
   input  wire                          dclk,
   input  wire                          rst,
   input  wire                          start_reconfig,
   output wire                          ready,
   output wire                          reconfig_done,
   input  wire pll_drp_pkg::time_t      clkout0_high_time,
   input  wire pll_drp_pkg::time_t      clkout0_low_time,
   input  wire pll_drp_pkg::phase_mux_t clkout0_phase_mux,
   input  wire                          clkout0_edge,
   input  wire                          clkout0_no_count,
   input  wire pll_drp_pkg::time_t      clkout0_delay_time,
   input  wire pll_drp_pkg::time_t      clkout1_high_time,
   input  wire pll_drp_pkg::time_t      clkout1_low_time,
   input  wire pll_drp_pkg::phase_mux_t clkout1_phase_mux,
   input  wire                          clkout1_edge,
   input  wire                          clkout1_no_count,
   input  wire pll_drp_pkg::time_t      clkout1_delay_time,
   input  wire pll_drp_pkg::time_t      clkfbout_high_time,
   input  wire pll_drp_pkg::time_t      clkfbout_low_time,
   input  wire pll_drp_pkg::phase_mux_t clkfbout_phase_mux,
   input  wire                          clkfbout_edge,
   input  wire                          clkfbout_no_count,
   input  wire pll_drp_pkg::time_t      clkfbout_delay_time,
   input  wire pll_drp_pkg::time_t      divclk_high_time,
   input  wire pll_drp_pkg::time_t      divclk_low_time,
   input  wire                          divclk_edge,
   input  wire                          divclk_no_count,
   output wire pll_drp_pkg::drp_addr_t  daddr,
   output wire pll_drp_pkg::drp_data_t  din,
   input  wire pll_drp_pkg::drp_data_t  dout,
   output wire                          den,
   output wire                          dwe,
   input  wire                          drdy,
   output wire                          rst_pll,
   input  wire                          locked
);
   import pll_drp_pkg::*;

   wire step_t        step;
   wire drp_addr_t    daddr_step;
   wire drp_data_t    keep_mask;
   wire drp_data_t    set_bits;
   wire lock_word_t   lock_word;
   wire filter_word_t filter_word;

   // Lock and filter words follow the DIVCLK settings
   pll_lock_filter_table u_table (.*);

   // Address, mask and new field bits of the current step
   pll_step_rom u_rom (.*);

   pll_drp_fsm u_fsm (.*);

endmodule

`default_nettype wire

// ==== tests/dclk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module dclk_gen (
   output logic dclk
);

   // 40 ns period
   initial begin
      dclk = 1'b0;
      forever #20 dclk = ~dclk;
   end

endmodule

`default_nettype wire

// ==== tests/pll_drp_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_drp_model (
   input  wire         dclk,
   input  wire  [6:0]  daddr,
   input  wire  [15:0] din,
   input  wire         den,
   input  wire         dwe,
   input  wire         rst_pll,
   output logic [15:0] dout,
   output logic        drdy,
   output logic        locked
);

   logic [15:0] regs [0:127];
   // One {dwe, daddr} entry per den pulse
   logic [7:0]  log_mem [0:255];
   integer      log_count;
   integer      seed;
   integer      delay;
   integer      lock_count;
   logic        busy;
   logic        overlap;
   logic        pend_we;
   logic [6:0]  pend_addr;
   logic [15:0] pend_din;

   initial begin
      for (int i = 0; i < 128; i++) begin
         regs[i] = 16'hA5A5;
      end
      seed       = 55;
      log_count  = 0;
      lock_count = 0;
      busy       = 1'b0;
      overlap    = 1'b0;
      drdy       = 1'b0;
      dout       = 16'h0000;
      locked     = 1'b0;
   end

   always @(posedge dclk) begin
      drdy <= 1'b0;
      if (den) begin
         // A second den before drdy breaks the DRP protocol
         if (busy) overlap <= 1'b1;
         if (log_count < 256) log_mem[log_count] <= {dwe, daddr};
         log_count <= log_count + 1;
         busy      <= 1'b1;
         pend_we   <= dwe;
         pend_addr <= daddr;
         pend_din  <= din;
         delay     <= {$random(seed)} % 4;
      end else if (busy) begin
         if (delay == 0) begin
            drdy <= 1'b1;
            busy <= 1'b0;
            if (pend_we) regs[pend_addr] <= pend_din;
            else dout <= regs[pend_addr];
         end else begin
            delay <= delay - 1;
         end
      end

      // Lock returns 3 cycles after the PLL leaves reset
      if (rst_pll) begin
         locked     <= 1'b0;
         lock_count <= 0;
      end else if (!locked) begin
         if (lock_count == 2) locked <= 1'b1;
         else lock_count <= lock_count + 1;
      end
   end

endmodule

`default_nettype wire

// ==== tests/pll_reconfig_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_tb;
   import pll_drp_pkg::*;

   localparam int NUM_VEC    = 5;
   localparam int NUM_FIELDS = 27;
   localparam int TIMEOUT    = 2000;

   wire dclk;
   logic rst, start_reconfig;
   time_t clkout0_high_time, clkout0_low_time, clkout0_delay_time;
   phase_mux_t clkout0_phase_mux;
   logic clkout0_edge, clkout0_no_count;
   time_t clkout1_high_time, clkout1_low_time, clkout1_delay_time;
   phase_mux_t clkout1_phase_mux;
   logic clkout1_edge, clkout1_no_count;
   time_t clkfbout_high_time, clkfbout_low_time, clkfbout_delay_time;
   phase_mux_t clkfbout_phase_mux;
   logic clkfbout_edge, clkfbout_no_count;
   time_t divclk_high_time, divclk_low_time;
   logic divclk_edge, divclk_no_count;
   wire ready, reconfig_done, den, dwe, drdy, rst_pll, locked;
   wire drp_addr_t daddr;
   wire drp_data_t din, dout;

   logic [15:0] vec_mem [0:NUM_VEC*NUM_FIELDS-1];
   int errors, tests, failed, done_count;
   logic in_seq;
   logic timed_out;

   drp_addr_t step_addrs [0:12] = '{ADDR_POWER, ADDR_CLKOUT0_REG1, ADDR_CLKOUT0_REG2,
      ADDR_CLKOUT1_REG1, ADDR_CLKOUT1_REG2, ADDR_DIVCLK, ADDR_CLKFBOUT_REG1,
      ADDR_CLKFBOUT_REG2, ADDR_LOCK_REG1, ADDR_LOCK_REG2, ADDR_LOCK_REG3,
      ADDR_FILT_REG1, ADDR_FILT_REG2};
   drp_data_t keep_masks [0:12] = '{16'h0000, 16'h1000, 16'hFC00, 16'h1000, 16'hFC00,
      16'hC000, 16'h1000, 16'hFC00, 16'hFC00, 16'h8000, 16'h8000, 16'h66FF, 16'h666F};

   dclk_gen clk_gen (.dclk(dclk));
   pll_drp_model drp (.*);
   pll_reconfig_top uut (.*);

   // Counter fields in file order high, low, phase mux, edge, no_count and delay
   function automatic logic [22:0] counter_fields(int b);
      return {vec_mem[b][5:0], vec_mem[b+1][5:0], vec_mem[b+2][2:0],
              vec_mem[b+3][0], vec_mem[b+4][0], vec_mem[b+5][5:0]};
   endfunction

   function automatic drp_data_t reg1_value(int b);
      return {vec_mem[b+2][2:0], 1'b0, vec_mem[b][5:0], vec_mem[b+1][5:0]};
   endfunction

   function automatic drp_data_t reg2_value(int b);
      return {8'h00, vec_mem[b+3][0], vec_mem[b+4][0], vec_mem[b+5][5:0]};
   endfunction

   task automatic load_vector(int v);
      int b;
      b = v * NUM_FIELDS;
      {clkout0_high_time, clkout0_low_time, clkout0_phase_mux, clkout0_edge,
       clkout0_no_count, clkout0_delay_time} = counter_fields(b);
      {clkout1_high_time, clkout1_low_time, clkout1_phase_mux, clkout1_edge,
       clkout1_no_count, clkout1_delay_time} = counter_fields(b + 6);
      {clkfbout_high_time, clkfbout_low_time, clkfbout_phase_mux, clkfbout_edge,
       clkfbout_no_count, clkfbout_delay_time} = counter_fields(b + 12);
      {divclk_high_time, divclk_low_time, divclk_edge, divclk_no_count} =
         {vec_mem[b+18][5:0], vec_mem[b+19][5:0], vec_mem[b+20][0], vec_mem[b+21][0]};
   endtask

   task automatic report_mismatch(string name, logic [15:0] got, logic [15:0] exp);
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic report_fail(string msg);
      $display("error at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic finish_test(string name, int err_before);
      tests++;
      if (errors != err_before) failed++;
      $display("test %0d %s: %s", tests, name, (errors == err_before) ? "pass" : "fail");
   endtask

   task automatic wait_for(bit for_done);
      int n;
      n = 0;
      while (!timed_out && !(for_done ? reconfig_done : ready) && n < TIMEOUT) begin
         @(negedge dclk);
         n++;
      end
      if (!timed_out && !(for_done ? reconfig_done : ready)) begin
         report_fail($sformatf("timed out waiting for %s",
                               for_done ? "reconfig_done" : "ready"));
         timed_out = 1'b1;
      end
   endtask

   task automatic run_vector(int v, bit hold_start);
      int b, k, first, done_before, err_before;
      drp_data_t bits [0:12];
      drp_data_t exp;
      b           = v * NUM_FIELDS;
      err_before  = errors;
      first       = drp.log_count;
      done_before = done_count;
      load_vector(v);
      start_reconfig = 1'b1;
      @(negedge dclk);
      if (!hold_start) start_reconfig = 1'b0;
      wait_for(1'b1);
      start_reconfig = 1'b0;
      wait_for(1'b0);

      bits[0] = 16'hFFFF;
      bits[1] = reg1_value(b);
      bits[2] = reg2_value(b);
      bits[3] = reg1_value(b + 6);
      bits[4] = reg2_value(b + 6);
      bits[5] = {2'b00, vec_mem[b+20][0], vec_mem[b+21][0], vec_mem[b+18][5:0],
                 vec_mem[b+19][5:0]};
      bits[6] = reg1_value(b + 12);
      bits[7] = reg2_value(b + 12);
      for (k = 8; k < NUM_STEPS; k++) begin
         bits[k] = vec_mem[b + 14 + k];
      end

      if (!timed_out) begin
         assert (drp.log_count - first == 2 * NUM_STEPS)
            else report_mismatch("access count", drp.log_count - first, 2 * NUM_STEPS);
         assert (done_count - done_before == 1)
            else report_mismatch("reconfig_done pulses", done_count - done_before, 1);
         assert (drp.overlap === 1'b0) else report_fail("den issued before previous drdy");
         for (k = 0; k < NUM_STEPS; k++) begin
            // Read then write of the same address
            assert (drp.log_mem[first + 2*k] === {1'b0, step_addrs[k]})
               else report_mismatch($sformatf("read access %0d", k),
                                    drp.log_mem[first + 2*k], {1'b0, step_addrs[k]});
            assert (drp.log_mem[first + 2*k + 1] === {1'b1, step_addrs[k]})
               else report_mismatch($sformatf("write access %0d", k),
                                    drp.log_mem[first + 2*k + 1], {1'b1, step_addrs[k]});
            exp = (16'hA5A5 & keep_masks[k]) | bits[k];
            assert (drp.regs[step_addrs[k]] === exp)
               else report_mismatch($sformatf("reg %02h", step_addrs[k]),
                                    drp.regs[step_addrs[k]], exp);
         end
      end
      finish_test($sformatf("vector %0d", v), err_before);
   endtask

   // PLL stays in reset from the first access until reconfig_done
   always @(negedge dclk) begin
      if (rst) begin
         in_seq = 1'b0;
      end else if (reconfig_done) begin
         done_count++;
         in_seq = 1'b0;
      end else begin
         if (den) in_seq = 1'b1;
         assert (!in_seq || rst_pll) else report_fail("rst_pll low during the sequence");
      end
   end

   initial begin
      errors     = 0;
      tests      = 0;
      failed     = 0;
      done_count = 0;
      in_seq     = 1'b0;
      timed_out  = 1'b0;
      $readmemh("tests/pll_reconfig_vectors.txt", vec_mem);
      rst            = 1'b1;
      start_reconfig = 1'b0;
      load_vector(0);
      repeat (2) @(negedge dclk);
      rst = 1'b0;
      assert (den === 1'b0 && dwe === 1'b0 && reconfig_done === 1'b0)
         else report_fail("DRP strobes or reconfig_done active after reset");
      wait_for(1'b0);
      if (!timed_out) begin
         assert (rst_pll === 1'b0) else report_mismatch("rst_pll", rst_pll, 16'h0000);
      end
      finish_test("reset and lock", 0);

      // Vector 1 holds start_reconfig through its whole sequence
      for (int v = 0; v < NUM_VEC; v++) begin
         if (!timed_out) begin
            run_vector(v, v == 1);
         end
      end
      if (!timed_out) begin
         assert (drp.log_count == NUM_VEC * 2 * NUM_STEPS)
            else report_fail("DRP accesses outside the reconfigurations");
      end

      $display("%0d tests run, %0d failed, %0d check errors", tests, failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/pll_drp_pkg.sv
verilog/pll_lock_filter_table.sv
verilog/pll_step_rom.sv
verilog/pll_drp_fsm.sv
verilog/pll_reconfig_top.sv
tests/dclk_gen.sv
tests/pll_drp_model.sv
tests/pll_reconfig_tb.sv

// ==== tests/pll_reconfig_vectors.txt ====
// clkout0, clkout1, clkfbout: high low phase_mux edge no_count delay
// divclk: high low edge no_count | lock_reg1 lock_reg2 lock_reg3 filt_reg1 filt_reg2
05 04 2 1 0 03  0A 0A 0 0 0 00  10 0F 5 1 0 3F  01 00 0 0  03E8 1801 1BE9 0900 1900
01 01 7 0 1 15  3F 3F 4 1 0 2A  08 08 0 0 0 00  03 03 1 0  03E8 4401 47E9 9100 1900
20 1F 1 1 0 01  02 03 6 1 1 3F  1F 20 3 0 0 0C  14 15 0 0  00FA 7C01 7FE9 0800 8000
3F 00 0 0 1 00  11 22 2 0 0 05  05 05 7 1 1 11  14 15 0 1  03E8 1801 1BE9 0900 1900
06 06 3 0 0 3E  07 08 1 1 0 10  2A 15 2 0 0 07  28 1E 1 0  03E8 1801 1BE9 0900 1900
